// ==== common/timer_pkg.sv ====
`default_nettype none

package timer_pkg;

  // bus geometry
  localparam int DATA_W = 32;
  localparam int BE_W = DATA_W / 8;
  localparam int ADR_W = 7;

  localparam int NUM_TIMERS = 4;
  localparam int CH_IDX_W = $clog2(NUM_TIMERS);
  localparam int TGT_IDX_W = $clog2(NUM_TIMERS + 1);
  localparam logic [TGT_IDX_W-1:0] ENC_IDX = TGT_IDX_W'(NUM_TIMERS); // last port goes to the encoder

  // address fields, byte address
  localparam int ENC_BASE_BIT = 6;
  localparam int CH_SEL_LSB = 4;
  localparam int REG_SEL_LSB = 2;
  localparam int REG_SEL_W = 2;

  // channel registers
  localparam logic [REG_SEL_W-1:0] REG_CTRL = 2'd0;
  localparam logic [REG_SEL_W-1:0] REG_RELOAD = 2'd1;
  localparam logic [REG_SEL_W-1:0] REG_COUNT = 2'd2;   // read only
  localparam logic [REG_SEL_W-1:0] REG_STATUS = 2'd3;  // w1c pending

  localparam int CTRL_W = 3;
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_AUTO_BIT = 1;
  localparam int CTRL_IRQEN_BIT = 2;

  // encoder registers at 0x40 / 0x44
  localparam logic [REG_SEL_W-1:0] ENC_REG_INTEN = 2'd0;
  localparam logic [REG_SEL_W-1:0] ENC_REG_VECTOR = 2'd1;

  // timer n raises VEC_BASE+n, 0 means nothing pending
  localparam int VEC_W = 3;
  localparam logic [VEC_W-1:0] VEC_BASE = 3'd2;

endpackage

`default_nettype wire

// ==== common/reg_port_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// register access path from the bus decoder to one register target
interface reg_port_if;

  logic wr_en;                                     // one cycle, commits with ack
  logic [timer_pkg::REG_SEL_W-1:0] reg_sel;        // always valid
  logic [timer_pkg::DATA_W-1:0] wdata;
  logic [timer_pkg::BE_W-1:0] be;
  logic [timer_pkg::DATA_W-1:0] rdata;             // combinational from target

  modport host (
    output wr_en,
    output reg_sel,
    output wdata,
    output be,
    input rdata
  );

  modport target (
    input wr_en,
    input reg_sel,
    input wdata,
    input be,
    output rdata
  );

endinterface

`default_nettype wire

// ==== src/timer_regs_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// wishbone classic slave in front of the timer and encoder register targets
module timer_regs_decoder (
  input wire logic sysclock,
  input wire logic rst_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_we_i,
  input wire logic [timer_pkg::ADR_W-1:0] wb_adr_i,
  input wire logic [timer_pkg::BE_W-1:0] wb_sel_i,
  input wire logic [timer_pkg::DATA_W-1:0] wb_dat_i,
  output logic [timer_pkg::DATA_W-1:0] wb_dat_o,
  output logic wb_ack_o,
  reg_port_if.host tgt_o [timer_pkg::NUM_TIMERS+1]
);

  logic ack_q;
  logic req;
  logic mapped;
  logic [timer_pkg::CH_IDX_W-1:0] ch_idx;
  logic [timer_pkg::TGT_IDX_W-1:0] tgt_idx;
  logic [timer_pkg::REG_SEL_W-1:0] reg_sel;
  logic [timer_pkg::DATA_W-1:0] rdata_arr [timer_pkg::NUM_TIMERS+1];
  logic [timer_pkg::DATA_W-1:0] rd_sel;
  logic [timer_pkg::DATA_W-1:0] dat_q;

  // new request only while ack is low, so back to back strobes ack every other cycle
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  assign ch_idx = wb_adr_i[timer_pkg::CH_SEL_LSB +: timer_pkg::CH_IDX_W];
  assign reg_sel = wb_adr_i[timer_pkg::REG_SEL_LSB +: timer_pkg::REG_SEL_W];

  always_comb begin
    if (wb_adr_i[timer_pkg::ENC_BASE_BIT]) begin
      tgt_idx = timer_pkg::ENC_IDX;
      // only 0x40 and 0x44 live in the encoder window
      mapped = (wb_adr_i[timer_pkg::ENC_BASE_BIT-1:timer_pkg::REG_SEL_LSB+1] == '0);
    end else begin
      tgt_idx = timer_pkg::TGT_IDX_W'(ch_idx);
      mapped = 1'b1;
    end
  end

  for (genvar t = 0; t <= timer_pkg::NUM_TIMERS; t++) begin : g_tgt
    logic hit;

    assign hit = mapped & (tgt_idx == timer_pkg::TGT_IDX_W'(t));
    assign tgt_o[t].wr_en = req & wb_we_i & hit;  // same edge as ack rising
    assign tgt_o[t].reg_sel = reg_sel;
    assign tgt_o[t].wdata = wb_dat_i;
    assign tgt_o[t].be = wb_sel_i;
    assign rdata_arr[t] = tgt_o[t].rdata;
  end

  assign rd_sel = rdata_arr[tgt_idx];

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // read data captured on the ack edge
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      dat_q <= '0;
    end else if (req) begin
      if (mapped && !wb_we_i) begin
        dat_q <= rd_sel;
      end else begin
        dat_q <= '0;  // unmapped reads 0
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule

`default_nettype wire

// ==== timer/timer_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

// one down counting timer
module timer_channel (
  input wire logic sysclock,
  input wire logic rst_i,
  reg_port_if.target regs_i,
  output logic irq_req_o
);

  logic [timer_pkg::CTRL_W-1:0] ctrl_q;
  logic [timer_pkg::DATA_W-1:0] reload_q;
  logic [timer_pkg::DATA_W-1:0] count_q;
  logic pending_q;

  logic ctrl_wr;
  logic reload_wr;
  logic status_wr;
  logic start;
  logic enabled;
  logic expire;

  assign ctrl_wr = regs_i.wr_en & (regs_i.reg_sel == timer_pkg::REG_CTRL) & regs_i.be[0];
  assign reload_wr = regs_i.wr_en & (regs_i.reg_sel == timer_pkg::REG_RELOAD);
  assign status_wr = regs_i.wr_en & (regs_i.reg_sel == timer_pkg::REG_STATUS) & regs_i.be[0];

  assign start = ctrl_wr & regs_i.wdata[timer_pkg::CTRL_EN_BIT];
  assign enabled = ctrl_q[timer_pkg::CTRL_EN_BIT];
  assign expire = enabled & (count_q == '0);

  // control, one-shot drops enable on expiry
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ctrl_q <= '0;
    end else if (ctrl_wr) begin
      ctrl_q <= regs_i.wdata[timer_pkg::CTRL_W-1:0];
    end else if (expire && !ctrl_q[timer_pkg::CTRL_AUTO_BIT]) begin
      ctrl_q[timer_pkg::CTRL_EN_BIT] <= 1'b0;
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      reload_q <= '0;
    end else if (reload_wr) begin
      for (int b = 0; b < timer_pkg::BE_W; b++) begin
        if (regs_i.be[b]) begin
          reload_q[8*b +: 8] <= regs_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // count is not bus writable
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (start) begin
      count_q <= reload_q;
    end else if (enabled) begin
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end else if (ctrl_q[timer_pkg::CTRL_AUTO_BIT]) begin
        count_q <= reload_q;
      end
    end
  end

  // a fresh expiry wins over a w1c in the same cycle
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (expire) begin
      pending_q <= 1'b1;
    end else if (status_wr && regs_i.wdata[0]) begin
      pending_q <= 1'b0;
    end
  end

  always_comb begin
    case (regs_i.reg_sel)
      timer_pkg::REG_CTRL: regs_i.rdata = timer_pkg::DATA_W'(ctrl_q);
      timer_pkg::REG_RELOAD: regs_i.rdata = reload_q;
      timer_pkg::REG_COUNT: regs_i.rdata = count_q;
      default: regs_i.rdata = timer_pkg::DATA_W'(pending_q);  // status
    endcase
  end

  assign irq_req_o = pending_q & ctrl_q[timer_pkg::CTRL_IRQEN_BIT];

endmodule

`default_nettype wire

// ==== src/irq_priority_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// fixed priority, highest timer index wins
module irq_priority_encoder (
  input wire logic sysclock,
  input wire logic rst_i,
  reg_port_if.target regs_i,
  input wire logic [timer_pkg::NUM_TIMERS-1:0] irq_req_i,
  output logic [timer_pkg::VEC_W-1:0] irq_vector_o,
  output logic irq_o
);

  logic inten_q;
  logic [timer_pkg::VEC_W-1:0] vector_q;
  logic [timer_pkg::VEC_W-1:0] vector_next;
  logic [timer_pkg::CH_IDX_W-1:0] win_idx;
  logic any_req;

  always_comb begin
    win_idx = '0;
    any_req = 1'b0;
    for (int i = 0; i < timer_pkg::NUM_TIMERS; i++) begin
      if (irq_req_i[i]) begin
        win_idx = timer_pkg::CH_IDX_W'(i);  // later index overrides
        any_req = 1'b1;
      end
    end
    if (inten_q && any_req) begin
      vector_next = timer_pkg::VEC_BASE + timer_pkg::VEC_W'(win_idx);
    end else begin
      vector_next = '0;
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      inten_q <= 1'b0;
    end else if (regs_i.wr_en && regs_i.be[0] &&
                 regs_i.reg_sel == timer_pkg::ENC_REG_INTEN) begin
      inten_q <= regs_i.wdata[0];
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      vector_q <= '0;
    end else begin
      vector_q <= vector_next;
    end
  end

  always_comb begin
    case (regs_i.reg_sel)
      timer_pkg::ENC_REG_INTEN: regs_i.rdata = timer_pkg::DATA_W'(inten_q);
      timer_pkg::ENC_REG_VECTOR: regs_i.rdata = timer_pkg::DATA_W'(vector_q);
      default: regs_i.rdata = '0;
    endcase
  end

  assign irq_vector_o = vector_q;
  assign irq_o = |vector_q;

endmodule

`default_nettype wire

// ==== src/timer_block.sv ====
`timescale 1ns/100ps
`default_nettype none

// four timers and the interrupt encoder behind one wishbone slave
module timer_block (
  input wire logic sysclock,
  input wire logic rst_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_we_i,
  input wire logic [timer_pkg::ADR_W-1:0] wb_adr_i,
  input wire logic [timer_pkg::BE_W-1:0] wb_sel_i,
  input wire logic [timer_pkg::DATA_W-1:0] wb_dat_i,
  output logic [timer_pkg::DATA_W-1:0] wb_dat_o,
  output logic wb_ack_o,
  output logic [timer_pkg::VEC_W-1:0] irq_vector_o,
  output logic irq_o
);

  // ports 0..3 are the channels, the last one the encoder
  reg_port_if u_port [timer_pkg::NUM_TIMERS+1] ();

  logic [timer_pkg::NUM_TIMERS-1:0] irq_req;

  timer_regs_decoder u_decoder (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .tgt_o    (u_port)
  );

  for (genvar g = 0; g < timer_pkg::NUM_TIMERS; g++) begin : g_timer
    timer_channel u_timer (
      .sysclock  (sysclock),
      .rst_i     (rst_i),
      .regs_i    (u_port[g]),
      .irq_req_o (irq_req[g])
    );
  end

  irq_priority_encoder u_irq_enc (
    .sysclock     (sysclock),
    .rst_i        (rst_i),
    .regs_i       (u_port[timer_pkg::NUM_TIMERS]),
    .irq_req_i    (irq_req),
    .irq_vector_o (irq_vector_o),
    .irq_o        (irq_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// 100 ns clock, reset held for the first 8 rising edges
module tb_clock_gen (
  output logic sysclock,
  output logic rst_o
);

  initial begin
    sysclock = 1'b0;
    forever #50 sysclock = ~sysclock;
  end

  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge sysclock);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/tb_timer_block.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_timer_block;

  logic sysclock;
  logic rst_i;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [6:0] wb_adr;
  logic [3:0] wb_sel;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;
  logic [2:0] irq_vector;
  logic irq;
  int errors;
  int timeouts;
  int unsigned cycle_cnt;
  logic [31:0] rng_state;

  tb_clock_gen u_clk (.sysclock(sysclock), .rst_o(rst_i));

  timer_block u_dut (
    .sysclock     (sysclock),
    .rst_i        (rst_i),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_sel_i     (wb_sel),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .irq_vector_o (irq_vector),
    .irq_o        (irq)
  );

  always @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // word address of a channel register
  function automatic logic [6:0] chan_addr(input logic [1:0] ch, input logic [1:0] reg_idx);
    return {1'b0, ch, reg_idx, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic bus_transfer(input logic we, input logic [6:0] adr, input logic [3:0] sel,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    logic got_ack;
    @(posedge sysclock);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_sel = sel;
    wb_dat_w = wdata;
    got_ack = 1'b0;
    waited = 0;
    while (!got_ack && waited < 20) begin
      @(posedge sysclock);
      #1;
      waited++;
      got_ack = wb_ack;
    end
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    if (!got_ack) begin
      timeouts++;
      $display("Timeout: no ack came for the access to address 0x%h", adr);
    end
  endtask

  task automatic wb_write(input logic [6:0] adr, input logic [31:0] data,
                          input logic [3:0] sel);
    logic [31:0] unused;
    bus_transfer(1'b1, adr, sel, data, unused);
  endtask

  task automatic wb_read(input logic [6:0] adr, output logic [31:0] data);
    bus_transfer(1'b0, adr, 4'hf, 32'h0, data);
  endtask

  task automatic wait_pending(input logic [1:0] ch, input int unsigned limit);
    logic [31:0] status;
    int unsigned start;
    logic seen;
    start = cycle_cnt;
    seen = 1'b0;
    while (!seen && (cycle_cnt - start) < limit) begin
      wb_read(chan_addr(ch, timer_pkg::REG_STATUS), status);
      seen = status[0];
    end
    if (!seen) begin
      timeouts++;
      $display("Timeout: channel %0d did not set pending within %0d cycles", ch, limit);
    end
  endtask

  task automatic wait_vector(input logic [2:0] expected, input int limit);
    int waited;
    waited = 0;
    while (irq_vector !== expected && waited < limit) begin
      @(posedge sysclock);
      #1;
      waited++;
    end
    if (irq_vector !== expected) begin
      timeouts++;
      $display("Timeout: interrupt vector did not become %0d within %0d cycles", expected, limit);
    end
  endtask

  task automatic read_reset_values();
    logic [31:0] rd;
    for (int ch = 0; ch < timer_pkg::NUM_TIMERS; ch++) begin
      for (int r = 0; r < 4; r++) begin
        wb_read(chan_addr(2'(ch), 2'(r)), rd);
        check_value($sformatf("ch%0d reg%0d after reset", ch, r), rd, 32'h0);
      end
    end
    wb_read(7'h40, rd);
    check_value("inten after reset", rd, 32'h0);
    wb_read(7'h44, rd);
    check_value("vector reg after reset", rd, 32'h0);
    check_value("irq_o", 32'(irq), 32'h0);
    check_value("irq_vector_o", 32'(irq_vector), 32'h0);
  endtask

  task automatic exercise_registers();
    logic [31:0] vals [4];
    logic [31:0] rd;
    for (int ch = 0; ch < timer_pkg::NUM_TIMERS; ch++) begin
      rng_state = xorshift32(rng_state);
      vals[ch] = rng_state;
      wb_write(chan_addr(2'(ch), timer_pkg::REG_RELOAD), vals[ch], 4'hf);
    end
    for (int ch = 0; ch < timer_pkg::NUM_TIMERS; ch++) begin
      wb_read(chan_addr(2'(ch), timer_pkg::REG_RELOAD), rd);
      check_value($sformatf("ch%0d reload", ch), rd, vals[ch]);
    end
    // only byte 1 may change
    wb_write(chan_addr(2'd0, timer_pkg::REG_RELOAD), 32'h1122_3344, 4'hf);
    wb_write(chan_addr(2'd0, timer_pkg::REG_RELOAD), 32'haabb_ccdd, 4'b0010);
    wb_read(chan_addr(2'd0, timer_pkg::REG_RELOAD), rd);
    check_value("ch0 reload byte write", rd, 32'h1122_cc44);
    wb_write(chan_addr(2'd1, timer_pkg::REG_COUNT), 32'h0000_5a5a, 4'hf);
    wb_read(chan_addr(2'd1, timer_pkg::REG_COUNT), rd);
    check_value("ch1 count after write", rd, 32'h0);
    for (int a = 'h48; a <= 'h7c; a += 4) begin
      wb_write(7'(a), 32'hffff_ffff, 4'hf);
      wb_read(7'(a), rd);
      check_value($sformatf("unmapped word 0x%h", a), rd, 32'h0);
    end
    wb_read(7'h40, rd);
    check_value("inten after unmapped writes", rd, 32'h0);
  endtask

  task automatic expire_one_shot();
    logic [31:0] rd;
    wb_write(chan_addr(2'd1, timer_pkg::REG_RELOAD), 32'd20, 4'hf);
    wb_write(chan_addr(2'd1, timer_pkg::REG_CTRL), 32'h1 << timer_pkg::CTRL_EN_BIT, 4'hf);
    wait_pending(2'd1, 100);
    wb_read(chan_addr(2'd1, timer_pkg::REG_COUNT), rd);
    check_value("ch1 count after expiry", rd, 32'h0);
    wb_read(chan_addr(2'd1, timer_pkg::REG_CTRL), rd);
    check_value("ch1 ctrl enable", 32'(rd[timer_pkg::CTRL_EN_BIT]), 32'h0);
    wb_write(chan_addr(2'd1, timer_pkg::REG_STATUS), 32'h1, 4'hf);
    wb_read(chan_addr(2'd1, timer_pkg::REG_STATUS), rd);
    check_value("ch1 status after clear", rd, 32'h0);
  endtask

  task automatic cycle_auto_reload();
    logic [31:0] rd;
    wb_write(chan_addr(2'd2, timer_pkg::REG_RELOAD), 32'd30, 4'hf);
    wb_write(chan_addr(2'd2, timer_pkg::REG_CTRL), (32'h1 << timer_pkg::CTRL_EN_BIT) |
             (32'h1 << timer_pkg::CTRL_AUTO_BIT), 4'hf);
    wait_pending(2'd2, 100);
    wb_read(chan_addr(2'd2, timer_pkg::REG_CTRL), rd);
    check_value("ch2 ctrl enable", 32'(rd[timer_pkg::CTRL_EN_BIT]), 32'h1);
    wb_read(chan_addr(2'd2, timer_pkg::REG_COUNT), rd);
    check_value("ch2 count within reload", 32'(rd <= 32'd30), 32'h1);
    wb_write(chan_addr(2'd2, timer_pkg::REG_STATUS), 32'h1, 4'hf);
    wb_read(chan_addr(2'd2, timer_pkg::REG_STATUS), rd);
    check_value("ch2 status after clear", rd, 32'h0);
    wait_pending(2'd2, 100);  // second period
    wb_write(chan_addr(2'd2, timer_pkg::REG_CTRL), 32'h0, 4'hf);
    wb_write(chan_addr(2'd2, timer_pkg::REG_STATUS), 32'h1, 4'hf);
  endtask

  task automatic irq_priority_order();
    logic [31:0] rd;
    logic [31:0] run_irq;
    run_irq = (32'h1 << timer_pkg::CTRL_EN_BIT) | (32'h1 << timer_pkg::CTRL_IRQEN_BIT);
    wb_write(7'h40, 32'h1, 4'hf);
    wb_write(chan_addr(2'd0, timer_pkg::REG_RELOAD), 32'd10, 4'hf);
    wb_write(chan_addr(2'd2, timer_pkg::REG_RELOAD), 32'd12, 4'hf);
    wb_write(chan_addr(2'd0, timer_pkg::REG_CTRL), run_irq, 4'hf);
    wb_write(chan_addr(2'd2, timer_pkg::REG_CTRL), run_irq, 4'hf);
    wait_vector(3'd4, 100);  // timer 2 beats timer 0
    check_value("irq_o with ch0 and ch2", 32'(irq), 32'h1);
    wb_read(7'h44, rd);
    check_value("vector reg with ch0 and ch2", rd, 32'h4);
    wb_write(chan_addr(2'd2, timer_pkg::REG_STATUS), 32'h1, 4'hf);
    wait_vector(3'd2, 20);
    wb_write(7'h40, 32'h0, 4'hf);
    wait_vector(3'd0, 20);
    check_value("irq_o with inten clear", 32'(irq), 32'h0);
    wb_write(chan_addr(2'd0, timer_pkg::REG_STATUS), 32'h1, 4'hf);
    // pending without channel irq enable must not reach the vector
    wb_write(7'h40, 32'h1, 4'hf);
    wb_write(chan_addr(2'd3, timer_pkg::REG_RELOAD), 32'd8, 4'hf);
    wb_write(chan_addr(2'd3, timer_pkg::REG_CTRL), 32'h1 << timer_pkg::CTRL_EN_BIT, 4'hf);
    wait_pending(2'd3, 100);
    repeat (4) begin
      @(posedge sysclock);
      #1;
      check_value("irq_vector_o with ch3 irq disabled", 32'(irq_vector), 32'h0);
    end
    wb_write(chan_addr(2'd3, timer_pkg::REG_STATUS), 32'h1, 4'hf);
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_i !== 1'b0 && waited < 20) begin
      @(posedge sysclock);
      waited++;
    end
    if (rst_i !== 1'b0) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
  endtask

  initial begin
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_sel = '0;
    wb_dat_w = '0;
    errors = 0;
    timeouts = 0;
    rng_state = 32'h3ec492cc;
    wait_reset_release();
    read_reset_values();
    exercise_registers();
    expire_one_shot();
    cycle_auto_reload();
    irq_priority_order();
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
common/timer_pkg.sv
common/reg_port_if.sv
src/timer_regs_decoder.sv
timer/timer_channel.sv
src/irq_priority_encoder.sv
src/timer_block.sv
bench/tb_clock_gen.sv
bench/tb_timer_block.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then decide on the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_timer_block \
  -f src.f -o tb_timer_block_sim > build.log 2>&1 \
  && ./obj_dir/tb_timer_block_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Testbench passed" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
